// File: fe_cfg.svh
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// Address and instruction widths
`define FE_VADDR_WIDTH 32
`define FE_PADDR_WIDTH 28
`define FE_PAGE_OFFSET_WIDTH 12
`define FE_INSTR_WIDTH 32

// Fully associative, so any count works
`define FE_ITLB_ENTRIES 4

// Starting address used by the testbench
`define FE_RESET_PC 32'h0000_1000

`endif

// File: fe_pkg.sv
`include "fe_cfg.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_WIDTH-1:0] vaddr_t;
  typedef logic [`FE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`FE_VADDR_WIDTH-`FE_PAGE_OFFSET_WIDTH-1:0] vtag_t;
  typedef logic [`FE_PADDR_WIDTH-`FE_PAGE_OFFSET_WIDTH-1:0] ptag_t;
  typedef logic [`FE_INSTR_WIDTH-1:0] instr_t;

  // Commands from the back end
  typedef enum logic [2:0]
  {
    e_op_state_reset = 3'd0,
    e_op_pc_redirect = 3'd1,
    e_op_itlb_fill   = 3'd2,
    e_op_itlb_fence  = 3'd3,
    e_op_wait        = 3'd4
  } fe_opcode_e;

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // Room left for more codes
  typedef enum logic [1:0]
  {
    e_itlb_miss = 2'd0,
    e_imem_miss = 2'd1
  } fe_exc_code_e;

endpackage

// File: fe_cmd_if.sv
`timescale 1ns/10ps

interface fe_cmd_if;

  import fe_pkg::*;

  logic   state_reset_v;
  logic   redirect_v;
  logic   itlb_fill_v;
  logic   itlb_fence_v;
  logic   wait_v;
  logic   any_v;
  vaddr_t cmd_vaddr;
  ptag_t  fill_ptag;
  logic   translation_en;

  modport decode
  (
    output state_reset_v, redirect_v, itlb_fill_v, itlb_fence_v, wait_v,
    output any_v, cmd_vaddr, fill_ptag, translation_en
  );

  modport exec
  (
    input state_reset_v, redirect_v, itlb_fill_v, itlb_fence_v, wait_v,
    input any_v, cmd_vaddr, fill_ptag, translation_en
  );

endinterface

// File: fe_if2_if.sv
`timescale 1ns/10ps

interface fe_if2_if;

  import fe_pkg::*;

  // Item state, from the fetch controller
  logic   v;
  vaddr_t pc;
  logic   itlb_miss;
  logic   kill;

  // Delivery outcome, from the result stage
  logic   deliver_v;
  logic   exception_v;
  logic   queue_ready;

  modport ctrl
  (
    output v, pc, itlb_miss, kill,
    input  deliver_v, exception_v, queue_ready
  );

  modport result
  (
    input  v, pc, itlb_miss, kill,
    output deliver_v, exception_v, queue_ready
  );

endinterface

// File: fe_cmd_decode.sv
`timescale 1ns/10ps

module fe_cmd_decode
  (input  logic               clk_i
  , input  logic              reset_i
  , input  logic              fe_cmd_v_i
  , input  fe_pkg::fe_opcode_e fe_cmd_opcode_i
  , input  fe_pkg::vaddr_t    fe_cmd_vaddr_i
  , input  fe_pkg::ptag_t     fe_cmd_ptag_i
  , input  logic              fe_cmd_translation_en_i
  , output logic              fe_cmd_yumi_o
  , fe_cmd_if.decode          cmd
  );

  import fe_pkg::*;

  logic translation_en_r;
  logic translation_en_w;

  // Every command is taken in the cycle it shows up
  assign fe_cmd_yumi_o = fe_cmd_v_i;

  assign cmd.state_reset_v = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_state_reset);
  assign cmd.redirect_v    = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_pc_redirect);
  assign cmd.itlb_fill_v   = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_itlb_fill);
  assign cmd.itlb_fence_v  = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_itlb_fence);
  assign cmd.wait_v        = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_wait);
  assign cmd.any_v         = fe_cmd_v_i;

  assign cmd.cmd_vaddr = fe_cmd_vaddr_i;
  assign cmd.fill_ptag = fe_cmd_ptag_i;

  // Shadow copy of the back end's translation mode
  assign translation_en_w = cmd.state_reset_v | cmd.redirect_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      translation_en_r <= 1'b0;
    end
    else if (translation_en_w)
    begin
      translation_en_r <= fe_cmd_translation_en_i;
    end
  end

  // New value is seen by the first fetch after the redirect
  assign cmd.translation_en = translation_en_w ? fe_cmd_translation_en_i : translation_en_r;

endmodule

// File: fe_itlb.sv
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_itlb
  (input  logic          clk_i
  , input  logic         reset_i
  , input  logic         fence_i
  , input  logic         fill_v_i
  , input  fe_pkg::vtag_t fill_vtag_i
  , input  fe_pkg::ptag_t fill_ptag_i
  , input  fe_pkg::vtag_t lookup_vtag_i
  , output fe_pkg::ptag_t ptag_o
  , output logic         miss_o
  );

  import fe_pkg::*;

  localparam int entries_lp   = `FE_ITLB_ENTRIES;
  localparam int idx_width_lp = (entries_lp > 1) ? $clog2(entries_lp) : 1;

  logic [entries_lp-1:0]   valid_r;
  vtag_t                   vtag_r [entries_lp];
  ptag_t                   ptag_r [entries_lp];
  logic [idx_width_lp-1:0] victim_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i | fence_i)
    begin
      valid_r  <= '0;
      victim_r <= '0;
    end
    else if (fill_v_i)
    begin
      valid_r[victim_r] <= 1'b1;
      // Round-robin replacement
      if (victim_r == idx_width_lp'(entries_lp - 1))
        victim_r <= '0;
      else
        victim_r <= victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
    begin
      vtag_r[victim_r] <= fill_vtag_i;
      ptag_r[victim_r] <= fill_ptag_i;
    end
  end

  always_comb
  begin
    ptag_o = '0;
    miss_o = 1'b1;
    for (int i = 0; i < entries_lp; i++)
    begin
      if (valid_r[i] && (vtag_r[i] == lookup_vtag_i))
      begin
        ptag_o = ptag_r[i];
        miss_o = 1'b0;
      end
    end
  end

endmodule

// File: fe_fetch_ctrl.sv
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_fetch_ctrl
  (input  logic            clk_i
  , input  logic           reset_i
  , fe_cmd_if.exec         cmd
  , fe_if2_if.ctrl         if2
  , output logic           imem_v_o
  , output fe_pkg::paddr_t imem_addr_o
  );

  import fe_pkg::*;

  fe_state_e state_r;
  fe_state_e state_n;

  vaddr_t npc_r;
  vaddr_t npc_n;
  vaddr_t resume_r;

  logic   v_if2_r;
  logic   v_if2_n;
  vaddr_t pc_if2_r;
  logic   miss_if2_r;

  vtag_t  if1_vtag;
  vtag_t  fill_vtag;
  ptag_t  tlb_ptag;
  logic   tlb_miss;
  logic   if1_miss;

  logic   cmd_immediate_v;
  logic   if2_fail_v;
  logic   if2_exc_done_v;
  logic   unstall;

  assign cmd_immediate_v = cmd.redirect_v | cmd.state_reset_v;
  assign if2_fail_v      = if2.v & ~if2.deliver_v;
  assign if2_exc_done_v  = if2.deliver_v & if2.exception_v;
  assign unstall         = (state_r == e_stall) & if2.queue_ready & ~cmd.any_v;

  assign if1_vtag  = npc_r[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];
  assign fill_vtag = cmd.cmd_vaddr[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];

  fe_itlb itlb
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.fence_i(cmd.itlb_fence_v)
    ,.fill_v_i(cmd.itlb_fill_v)
    ,.fill_vtag_i(fill_vtag)
    ,.fill_ptag_i(cmd.fill_ptag)
    ,.lookup_vtag_i(if1_vtag)
    ,.ptag_o(tlb_ptag)
    ,.miss_o(tlb_miss)
    );

  // IF1: translate and issue the request
  assign if1_miss    = cmd.translation_en & tlb_miss;
  assign imem_v_o    = (state_r == e_run) & ~if1_miss;
  assign imem_addr_o = cmd.translation_en
                       ? {tlb_ptag, npc_r[`FE_PAGE_OFFSET_WIDTH-1:0]}
                       : npc_r[`FE_PADDR_WIDTH-1:0];

  always_comb
  begin
    case (state_r)
      e_wait:  state_n = cmd_immediate_v ? e_run : (cmd.wait_v ? e_stall : e_wait);
      e_stall: state_n = (cmd_immediate_v | unstall) ? e_run : e_stall;
      // A failed delivery or a non-redirect command parks in stall
      e_run:   state_n = cmd_immediate_v
                         ? e_run
                         : (if2_fail_v | cmd.any_v)
                           ? e_stall
                           : if2_exc_done_v ? e_wait : e_run;
      default: state_n = e_wait;
    endcase
  end

  always_comb
  begin
    if (cmd_immediate_v)
      npc_n = cmd.cmd_vaddr;
    else if (unstall)
      npc_n = resume_r;
    else if (state_r == e_run)
      npc_n = npc_r + vaddr_t'(4);
    else
      npc_n = npc_r;
  end

  // The IF1 item is dropped when IF2 stalls, traps or a command arrives
  assign v_if2_n = (state_r == e_run) & ~if2_fail_v & ~if2_exc_done_v & ~cmd.any_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_wait;
      v_if2_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      v_if2_r <= v_if2_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    npc_r      <= npc_n;
    pc_if2_r   <= npc_r;
    miss_if2_r <= if1_miss;
  end

  // Command PC wins over the refetch point of a failed item
  always_ff @(posedge clk_i)
  begin
    if (cmd.any_v)
      resume_r <= cmd.cmd_vaddr;
    else if (if2_fail_v)
      resume_r <= pc_if2_r;
  end

  assign if2.v         = v_if2_r;
  assign if2.pc        = pc_if2_r;
  assign if2.itlb_miss = miss_if2_r;
  assign if2.kill      = cmd.any_v;

endmodule

// File: fe_queue_result.sv
`timescale 1ns/10ps

module fe_queue_result
  (fe_if2_if.result               if2
  , input  fe_pkg::instr_t        imem_data_i
  , input  logic                  imem_data_v_i
  , input  logic                  fe_queue_ready_i
  , output logic                  fe_queue_v_o
  , output fe_pkg::fe_msg_type_e  fe_queue_type_o
  , output fe_pkg::vaddr_t        fe_queue_pc_o
  , output fe_pkg::instr_t        fe_queue_instr_o
  , output fe_pkg::fe_exc_code_e  fe_queue_exc_o
  );

  import fe_pkg::*;

  logic exception;

  // No data back means either no request went out or the memory missed
  assign exception = if2.itlb_miss | ~imem_data_v_i;

  assign if2.exception_v = if2.v & exception;
  assign if2.deliver_v   = if2.v & fe_queue_ready_i & ~if2.kill;
  assign if2.queue_ready = fe_queue_ready_i;

  assign fe_queue_v_o    = if2.deliver_v;
  assign fe_queue_type_o = exception ? e_fe_exception : e_fe_fetch;
  assign fe_queue_pc_o   = if2.pc;
  assign fe_queue_instr_o = exception ? '0 : imem_data_i;

  // ITLB miss takes priority
  assign fe_queue_exc_o = if2.itlb_miss ? e_itlb_miss : e_imem_miss;

endmodule

// File: fe_top.sv
`timescale 1ns/10ps

module fe_top
  (input  logic                  clk_i
  , input  logic                 reset_i

  , input  logic                 fe_cmd_v_i
  , input  fe_pkg::fe_opcode_e   fe_cmd_opcode_i
  , input  fe_pkg::vaddr_t       fe_cmd_vaddr_i
  , input  fe_pkg::ptag_t        fe_cmd_ptag_i
  , input  logic                 fe_cmd_translation_en_i
  , output logic                 fe_cmd_yumi_o

  , output logic                 imem_v_o
  , output fe_pkg::paddr_t       imem_addr_o
  , input  fe_pkg::instr_t       imem_data_i
  , input  logic                 imem_data_v_i

  , input  logic                 fe_queue_ready_i
  , output logic                 fe_queue_v_o
  , output fe_pkg::fe_msg_type_e fe_queue_type_o
  , output fe_pkg::vaddr_t       fe_queue_pc_o
  , output fe_pkg::instr_t       fe_queue_instr_o
  , output fe_pkg::fe_exc_code_e fe_queue_exc_o
  );

  fe_cmd_if cmd_if ();
  fe_if2_if if2_if ();

  fe_cmd_decode decode
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.fe_cmd_v_i(fe_cmd_v_i)
    ,.fe_cmd_opcode_i(fe_cmd_opcode_i)
    ,.fe_cmd_vaddr_i(fe_cmd_vaddr_i)
    ,.fe_cmd_ptag_i(fe_cmd_ptag_i)
    ,.fe_cmd_translation_en_i(fe_cmd_translation_en_i)
    ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
    ,.cmd(cmd_if.decode)
    );

  fe_fetch_ctrl fetch_ctrl
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.cmd(cmd_if.exec)
    ,.if2(if2_if.ctrl)
    ,.imem_v_o(imem_v_o)
    ,.imem_addr_o(imem_addr_o)
    );

  fe_queue_result queue_result
    (.if2(if2_if.result)
    ,.imem_data_i(imem_data_i)
    ,.imem_data_v_i(imem_data_v_i)
    ,.fe_queue_ready_i(fe_queue_ready_i)
    ,.fe_queue_v_o(fe_queue_v_o)
    ,.fe_queue_type_o(fe_queue_type_o)
    ,.fe_queue_pc_o(fe_queue_pc_o)
    ,.fe_queue_instr_o(fe_queue_instr_o)
    ,.fe_queue_exc_o(fe_queue_exc_o)
    );

endmodule

// File: tb_fe_top.sv
`timescale 1ns/10ps
`include "fe_cfg.svh"

module tb_fe_top;

  import fe_pkg::*;

  typedef struct {
    fe_opcode_e op;
    vaddr_t     vaddr;
    ptag_t      ptag;
    logic       tr_en;
    logic       rand_ready;
    int         n_msgs;
    logic       stop;
    paddr_t     miss_pa;
  } row_t;

  localparam instr_t mem_key     = 32'h5a5a_5a5a;
  localparam paddr_t no_miss     = 28'hfff_fffc;
  localparam int     msg_timeout = 200;

  logic         clk_i;
  logic         reset_i;
  logic         fe_cmd_v_i;
  fe_opcode_e   fe_cmd_opcode_i;
  vaddr_t       fe_cmd_vaddr_i;
  ptag_t        fe_cmd_ptag_i;
  logic         fe_cmd_translation_en_i;
  logic         fe_cmd_yumi_o;
  logic         imem_v_o;
  paddr_t       imem_addr_o;
  instr_t       imem_data_i;
  logic         imem_data_v_i;
  logic         fe_queue_ready_i;
  logic         fe_queue_v_o;
  fe_msg_type_e fe_queue_type_o;
  vaddr_t       fe_queue_pc_o;
  instr_t       fe_queue_instr_o;
  fe_exc_code_e fe_queue_exc_o;

  row_t   rows [$];
  paddr_t cur_miss;
  integer seed;
  int     error_count;
  int     timeout_count;
  int     msg_count;

  // Reference model state
  vaddr_t                        exp_pc;
  logic                          exp_tr;
  logic [`FE_ITLB_ENTRIES-1:0]   tlb_v;
  vtag_t                         tlb_vtag [`FE_ITLB_ENTRIES];
  ptag_t                         tlb_ptag [`FE_ITLB_ENTRIES];
  int                            victim;

  fe_top DUT (.*);

  always #50 clk_i = ~clk_i;

  // Instruction memory answers one cycle after the request
  always @(posedge clk_i)
  begin
    imem_data_i   <= instr_t'(imem_addr_o) ^ mem_key;
    imem_data_v_i <= imem_v_o & (imem_addr_o != cur_miss);
  end

  task automatic add_row(input fe_opcode_e op, input vaddr_t va, input ptag_t pt,
                         input logic tr, input logic rnd, input int n, input logic stop,
                         input paddr_t miss);
    row_t r;
    r.op = op;
    r.vaddr = va;
    r.ptag = pt;
    r.tr_en = tr;
    r.rand_ready = rnd;
    r.n_msgs = n;
    r.stop = stop;
    r.miss_pa = miss;
    rows.push_back(r);
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL t=%0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_fetch(input vaddr_t pc, input instr_t instr);
    if (fe_queue_type_o !== e_fe_fetch || fe_queue_pc_o !== pc || fe_queue_instr_o !== instr)
    begin
      error_count++;
      $display("FAIL t=%0t fetch: got type %0d pc %h instr %h, expected pc %h instr %h",
               $time, fe_queue_type_o, fe_queue_pc_o, fe_queue_instr_o, pc, instr);
    end
  endtask

  // Exception messages carry a cleared instruction field
  task automatic check_exception(input vaddr_t pc, input fe_exc_code_e code);
    if (fe_queue_type_o !== e_fe_exception || fe_queue_pc_o !== pc
        || fe_queue_exc_o !== code || fe_queue_instr_o !== '0)
    begin
      error_count++;
      $display("FAIL t=%0t exception: got type %0d pc %h code %0d instr %h, expected pc %h code %0d",
               $time, fe_queue_type_o, fe_queue_pc_o, fe_queue_exc_o, fe_queue_instr_o,
               pc, code);
    end
  endtask

  // Translation as the back end expects it, returns 0 on an ITLB miss
  function automatic logic translate(input vaddr_t va, output paddr_t pa);
    ptag_t pt;
    logic  hit;
    pt = '0;
    hit = 1'b0;
    for (int i = 0; i < `FE_ITLB_ENTRIES; i++)
    begin
      if (tlb_v[i] && tlb_vtag[i] == va[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH])
      begin
        hit = 1'b1;
        pt = tlb_ptag[i];
      end
    end
    if (!exp_tr)
    begin
      pa = va[`FE_PADDR_WIDTH-1:0];
      return 1'b1;
    end
    pa = {pt, va[`FE_PAGE_OFFSET_WIDTH-1:0]};
    return hit;
  endfunction

  task automatic model_command(input row_t row);
    exp_pc = row.vaddr;
    case (row.op)
      e_op_state_reset, e_op_pc_redirect: exp_tr = row.tr_en;
      e_op_itlb_fill:
      begin
        tlb_v[victim] = 1'b1;
        tlb_vtag[victim] = row.vaddr[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];
        tlb_ptag[victim] = row.ptag;
        victim = (victim == `FE_ITLB_ENTRIES - 1) ? 0 : victim + 1;
      end
      e_op_itlb_fence:
      begin
        tlb_v = '0;
        victim = 0;
      end
      default: ;
    endcase
  endtask

  task automatic take_message();
    paddr_t pa;
    logic   mapped;
    mapped = translate(exp_pc, pa);
    msg_count++;
    if (!mapped)
      check_exception(exp_pc, e_itlb_miss);
    else if (pa == cur_miss)
      check_exception(exp_pc, e_imem_miss);
    else
    begin
      check_fetch(exp_pc, instr_t'(pa) ^ mem_key);
      exp_pc = exp_pc + vaddr_t'(4);
    end
  endtask

  task automatic drive_cycle(input logic ready);
    @(posedge clk_i);
    fe_cmd_v_i       <= 1'b0;
    fe_queue_ready_i <= ready;
    @(negedge clk_i);
  endtask

  task automatic issue_command(input row_t row);
    @(posedge clk_i);
    fe_cmd_v_i              <= 1'b1;
    fe_cmd_opcode_i         <= row.op;
    fe_cmd_vaddr_i          <= row.vaddr;
    fe_cmd_ptag_i           <= row.ptag;
    fe_cmd_translation_en_i <= row.tr_en;
    fe_queue_ready_i        <= 1'b1;
    cur_miss                <= row.miss_pa;
    @(negedge clk_i);
    check_level("queue valid during command", fe_queue_v_o, 1'b0);
    check_level("command accept", fe_cmd_yumi_o, 1'b1);
  endtask

  task automatic wait_message(input logic rand_ready, input int row_idx);
    int   cyc;
    logic got;
    logic ready;
    cyc = 0;
    got = 1'b0;
    while (!got && cyc < msg_timeout)
    begin
      ready = rand_ready ? 1'($random(seed)) : 1'b1;
      drive_cycle(ready);
      if (!ready)
        check_level("queue valid without ready", fe_queue_v_o, 1'b0);
      if (fe_queue_v_o)
      begin
        got = 1'b1;
        take_message();
      end
      cyc++;
    end
    if (!got)
    begin
      timeout_count++;
      $display("Timeout: no queue message within %0d cycles in row %0d", msg_timeout, row_idx);
    end
  endtask

  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      drive_cycle(1'b1);
      check_level("imem request while idle", imem_v_o, 1'b0);
      check_level("queue valid while idle", fe_queue_v_o, 1'b0);
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    fe_cmd_v_i = 1'b0;
    fe_cmd_opcode_i = e_op_wait;
    fe_cmd_vaddr_i = '0;
    fe_cmd_ptag_i = '0;
    fe_cmd_translation_en_i = 1'b0;
    fe_queue_ready_i = 1'b0;
    cur_miss = no_miss;
    seed = 17625;
    error_count = 0;
    timeout_count = 0;
    msg_count = 0;
    exp_pc = '0;
    exp_tr = 1'b0;
    tlb_v = '0;
    victim = 0;

    // op, vaddr, ptag, translation, random ready, messages, stops, miss address
    add_row(e_op_state_reset, `FE_RESET_PC, 16'h0, 1'b0, 1'b0, 6, 1'b0, no_miss);
    add_row(e_op_pc_redirect, 32'h0000_2000, 16'h0, 1'b0, 1'b1, 20, 1'b0, no_miss);
    add_row(e_op_pc_redirect, 32'h0003_4000, 16'h0, 1'b1, 1'b0, 1, 1'b1, no_miss);
    add_row(e_op_itlb_fill, 32'h0003_4000, 16'h0056, 1'b0, 1'b0, 0, 1'b1, no_miss);
    add_row(e_op_pc_redirect, 32'h0003_4ff0, 16'h0, 1'b1, 1'b1, 5, 1'b1, no_miss);
    add_row(e_op_pc_redirect, 32'h0003_4100, 16'h0, 1'b1, 1'b1, 4, 1'b1, 28'h005_610c);
    add_row(e_op_itlb_fence, 32'h0003_4000, 16'h0, 1'b0, 1'b0, 0, 1'b1, no_miss);
    add_row(e_op_pc_redirect, 32'h0003_4000, 16'h0, 1'b1, 1'b0, 1, 1'b1, no_miss);
    add_row(e_op_pc_redirect, `FE_RESET_PC, 16'h0, 1'b0, 1'b1, 12, 1'b0, no_miss);
    add_row(e_op_wait, 32'h0000_1100, 16'h0, 1'b0, 1'b1, 4, 1'b0, no_miss);

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    check_idle(6);

    for (int r = 0; r < rows.size() && timeout_count == 0; r++)
    begin
      issue_command(rows[r]);
      model_command(rows[r]);
      for (int m = 0; m < rows[r].n_msgs && timeout_count == 0; m++)
        wait_message(rows[r].rand_ready, r);
      if (rows[r].stop && timeout_count == 0)
        check_idle(5);
    end

    $display("Summary: %0d mismatches, %0d timeouts, %0d messages checked",
             error_count, timeout_count, msg_count);
    if (error_count == 0 && timeout_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: fe_lite.f
+incdir+.
fe_pkg.sv
fe_cmd_if.sv
fe_if2_if.sv
fe_cmd_decode.sv
fe_itlb.sv
fe_fetch_ctrl.sv
fe_queue_result.sv
fe_top.sv
tb_fe_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fe_top -f fe_lite.f

output=$(./obj_dir/Vtb_fe_top)
echo "$output"

if echo "$output" | grep -qF -- '*** PASSED ***'; then
  exit 0
else
  exit 1
fi
